/* rtl/mdu_pkg.sv */
package mdu_pkg;

    localparam int xlen       = 64;
    localparam int word_w     = 32;
    localparam int step_count = 64;
    localparam int cnt_w      = $clog2(step_count);

    // bit 2 word form, bit 1 remainder, bit 0 unsigned.
    typedef enum logic [2:0] {
        op_div   = 3'b000,
        op_divu  = 3'b001,
        op_rem   = 3'b010,
        op_remu  = 3'b011,
        op_divw  = 3'b100,
        op_divuw = 3'b101,
        op_remw  = 3'b110,
        op_remuw = 3'b111
    } div_op_e;

    typedef struct packed {
        div_op_e         op;
        logic [xlen-1:0] dividend;
        logic [xlen-1:0] divisor;
    } div_req_t;

    typedef struct packed {
        div_op_e         op;
        logic [xlen-1:0] dividend_mag;
        logic [xlen-1:0] divisor_mag;
        logic            neg_quot;
        logic            neg_rem;
        logic            div_zero;
        logic [xlen-1:0] dividend;  // extended, before abs.
    } div_prep_t;

    typedef struct packed {
        logic [xlen-1:0] quot;
        logic [xlen-1:0] rem;
    } div_raw_t;

    function automatic logic op_is_word(div_op_e op);
        return op[2];
    endfunction

    function automatic logic op_is_rem(div_op_e op);
        return op[1];
    endfunction

    function automatic logic op_is_unsigned(div_op_e op);
        return op[0];
    endfunction

endpackage

/* rtl/div_operand_prep.sv */
`timescale 1ns/1ps

module div_operand_prep import mdu_pkg::*; (
    input  div_req_t  req,
    output div_prep_t prep
);

    logic            word_op;
    logic            signed_op;
    logic [xlen-1:0] a_ext;
    logic [xlen-1:0] b_ext;
    logic            a_neg;
    logic            b_neg;
    logic            b_zero;

    always_comb begin
        word_op   = op_is_word(req.op);
        signed_op = !op_is_unsigned(req.op);

        // word forms only look at the low half.
        if (word_op && signed_op) begin
            a_ext = {{(xlen-word_w){req.dividend[word_w-1]}}, req.dividend[word_w-1:0]};
            b_ext = {{(xlen-word_w){req.divisor[word_w-1]}}, req.divisor[word_w-1:0]};
        end else if (word_op) begin
            a_ext = {{(xlen-word_w){1'b0}}, req.dividend[word_w-1:0]};
            b_ext = {{(xlen-word_w){1'b0}}, req.divisor[word_w-1:0]};
        end else begin
            a_ext = req.dividend;
            b_ext = req.divisor;
        end

        a_neg  = signed_op && a_ext[xlen-1];
        b_neg  = signed_op && b_ext[xlen-1];
        b_zero = (b_ext == '0);

        prep.op           = req.op;
        prep.dividend_mag = a_neg ? (~a_ext + 1'b1) : a_ext;  // min value stays 2^63.
        prep.divisor_mag  = b_neg ? (~b_ext + 1'b1) : b_ext;
        prep.neg_quot     = (a_neg ^ b_neg) && !b_zero;
        prep.neg_rem      = a_neg;  // remainder follows dividend sign.
        prep.div_zero     = b_zero;
        prep.dividend     = a_ext;
    end

    // overflow needs no flag.
    // 2^63 / 1 negated wraps back to the dividend, remainder 0.

endmodule

/* rtl/div_core.sv */
`timescale 1ns/1ps

module div_core import mdu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      flush,
    input  div_prep_t prep_in,
    output logic      div_ready,
    output logic      done,
    output div_prep_t meta,
    output div_raw_t  raw
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_finish
    } state_e;

    state_e            state;
    logic [cnt_w-1:0]  step;
    logic              done_q;
    logic [2*xlen-1:0] acc;        // remainder high, quotient low.
    logic [xlen:0]     rem_shift;  // one extra bit, shifted remainder may pass 2^64.
    logic              rem_ge;
    logic [2*xlen-1:0] acc_next;

    // one restoring step.
    always_comb begin
        rem_shift = acc[2*xlen-1:xlen-1];
        rem_ge    = (rem_shift >= {1'b0, meta.divisor_mag});
        if (rem_ge) begin
            acc_next = {rem_shift[xlen-1:0] - meta.divisor_mag, acc[xlen-2:0], 1'b1};
        end else begin
            acc_next = {acc[2*xlen-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            step      <= '0;
            div_ready <= 1'b1;
            done_q    <= 1'b0;
        end else if (start) begin
            state     <= st_run;  // also restarts over a running op.
            step      <= '0;
            div_ready <= 1'b0;
            done_q    <= 1'b0;
        end else if (flush) begin
            state     <= st_idle;
            div_ready <= 1'b1;
            done_q    <= 1'b0;
        end else begin
            case (state)
                st_run: begin
                    step <= step + 1'b1;
                    if (step == cnt_w'(step_count - 1)) begin
                        state  <= st_finish;
                        done_q <= 1'b1;
                    end
                end
                st_finish: begin
                    // first cycle carries done, second waits out out_valid.
                    if (done_q) begin
                        done_q <= 1'b0;
                    end else begin
                        state     <= st_idle;
                        div_ready <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            meta <= prep_in;
            acc  <= {{xlen{1'b0}}, prep_in.dividend_mag};
        end else if (state == st_run && !flush) begin
            acc <= acc_next;
        end
    end

    // a flush in the done cycle still drops the old result.
    assign done     = done_q & ~flush;
    assign raw.quot = acc[xlen-1:0];
    assign raw.rem  = acc[2*xlen-1:xlen];

endmodule

/* rtl/div_result_fix.sv */
`timescale 1ns/1ps

module div_result_fix import mdu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            done,
    input  div_prep_t       meta,
    input  div_raw_t        raw,
    output logic            out_valid,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] quot;
    logic [xlen-1:0] rem;
    logic [xlen-1:0] sel;
    logic [xlen-1:0] res_next;

    always_comb begin
        quot = meta.neg_quot ? (~raw.quot + 1'b1) : raw.quot;
        rem  = meta.neg_rem ? (~raw.rem + 1'b1) : raw.rem;

        // divide by zero per riscv.
        if (meta.div_zero) begin
            quot = '1;
            rem  = meta.dividend;
        end

        sel = op_is_rem(meta.op) ? rem : quot;

        if (op_is_word(meta.op)) begin
            res_next = {{(xlen-word_w){sel[word_w-1]}}, sel[word_w-1:0]};  // also for divuw.
        end else begin
            res_next = sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= done;  // single cycle, done is one.
        end
    end

    // held until the next done.
    always_ff @(posedge clk) begin
        if (done) begin
            result <= res_next;
        end
    end

endmodule

/* rtl/div_unit.sv */
`timescale 1ns/1ps

module div_unit import mdu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            div_valid,
    input  logic            flush,
    input  div_req_t        req,
    output logic            div_ready,
    output logic            out_valid,
    output logic [xlen-1:0] result
);

    div_prep_t prep;
    div_prep_t meta;
    div_raw_t  raw;
    logic      start;
    logic      done;

    // flush lets a new op in while busy.
    assign start = div_valid & (div_ready | flush);

    div_operand_prep prep_i (
        .req  (req),
        .prep (prep)
    );

    div_core core_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .flush     (flush),
        .prep_in   (prep),
        .div_ready (div_ready),
        .done      (done),
        .meta      (meta),
        .raw       (raw)
    );

    div_result_fix fix_i (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .meta      (meta),
        .raw       (raw),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    // ten rising edges in reset.
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb/div_unit_properties.sv */
`timescale 1ns/1ps

module div_unit_properties (
    input logic clk,
    input logic rst,
    input logic div_ready,
    input logic out_valid
);

    int assert_errs = 0;  // failed assertion count.

    pulse_len: assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid)
        else begin
            assert_errs++;
            $error("out_valid stayed high for more than one cycle");
        end

    // a result never shows while idle.
    no_valid_idle: assert property (@(posedge clk) disable iff (rst) !(out_valid && div_ready))
        else begin
            assert_errs++;
            $error("out_valid was high while div_ready was high");
        end

    reset_state: assert property (@(posedge clk) rst |=> (div_ready && !out_valid))
        else begin
            assert_errs++;
            $error("div_ready low or out_valid high right after reset");
        end

endmodule

/* tb/div_unit_checker.sv */
`timescale 1ns/1ps

module div_unit_checker import mdu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            div_valid,
    input  logic            flush,
    input  div_req_t        req,
    input  logic            exp_chk,
    input  logic [xlen-1:0] exp_val,
    input  logic            div_ready,
    input  logic            out_valid,
    input  logic [xlen-1:0] result,
    output int              value_errs,
    output int              timing_errs
);

    logic            pending;    // an accepted op still owes a result.
    logic            ready_due;
    int              cycles;
    div_req_t        cur;
    logic            cur_chk;
    logic [xlen-1:0] cur_tbl;

    // riscv m-extension divide rules.
    function automatic logic [xlen-1:0] model(div_req_t r);
        logic                   word;
        logic                   uns;
        logic [xlen-1:0]        a;
        logic [xlen-1:0]        b;
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        logic [xlen-1:0]        q;
        logic [xlen-1:0]        m;
        word = r.op inside {op_divw, op_divuw, op_remw, op_remuw};
        uns  = r.op inside {op_divu, op_remu, op_divuw, op_remuw};
        a    = r.dividend;
        b    = r.divisor;
        if (word) begin
            a = uns ? {32'b0, a[31:0]} : {{32{a[31]}}, a[31:0]};
            b = uns ? {32'b0, b[31:0]} : {{32{b[31]}}, b[31:0]};
        end
        sa = a;
        sb = b;
        if (b == '0) begin
            q = '1;
            m = a;
        end else if (uns) begin
            q = a / b;
            m = a % b;
        end else if (a == {1'b1, 63'b0} && sb == -1) begin
            q = a;  // overflow.
            m = '0;
        end else begin
            q = sa / sb;
            m = sa % sb;
        end
        q = (r.op inside {op_rem, op_remu, op_remw, op_remuw}) ? m : q;
        return word ? {{32{q[31]}}, q[31:0]} : q;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            pending     = 1'b0;
            ready_due   = 1'b0;
            value_errs  = 0;
            timing_errs = 0;
        end else begin
            if (ready_due && !div_ready) begin
                timing_errs++;
                $display("Timing error at %0t: div_ready did not return on the next edge", $time);
            end
            ready_due = 1'b0;
            if (pending) begin
                cycles++;
            end
            if (out_valid && !pending) begin
                timing_errs++;
                $display("Timing error at %0t: out_valid without an accepted operation", $time);
            end else if (out_valid) begin
                if (cycles != 66) begin
                    timing_errs++;
                    $display("Timing error at %0t: out_valid came %0d cycles after the start",
                             $time, cycles);
                end
                if (result !== model(cur) || (cur_chk && result !== cur_tbl)) begin
                    value_errs++;
                    $display("Mismatch at %0t: %s a=%h b=%h got %h, model %h, table %h",
                             $time, cur.op.name(), cur.dividend, cur.divisor, result,
                             model(cur), cur_tbl);
                end
                pending   = 1'b0;
                ready_due = 1'b1;
            end
            if (div_valid && (div_ready || flush)) begin
                pending = 1'b1;
                cycles  = 0;
                cur     = req;
                cur_chk = exp_chk;
                cur_tbl = exp_val;
            end else if (flush) begin
                pending   = 1'b0;  // aborted, no result allowed.
                ready_due = 1'b1;
            end
        end
    end

endmodule

/* tb/div_unit_tb.sv */
`timescale 1ns/1ps

module div_unit_tb import mdu_pkg::*; ();

    typedef struct packed {
        div_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] exp;
        logic            chk;
        logic [1:0]      mode;  // 0 plain, 1 flush with a new op, 2 flush alone.
        logic [7:0]      fa;    // falling edges before the flush.
    } stim_t;

    logic            clk;
    logic            rst;
    logic            div_valid;
    logic            flush;
    div_req_t        req;
    logic            exp_chk;
    logic [xlen-1:0] exp_val;
    logic            div_ready;
    logic            out_valid;
    logic [xlen-1:0] result;
    int              value_errs;
    int              timing_errs;
    int              timeout_errs;
    logic [15:0]     lfsr;
    stim_t           stim_q[$];

    tb_clock_gen clk_gen_i (.clk(clk), .rst(rst));

    div_unit dut_i (
        .clk       (clk),
        .rst       (rst),
        .div_valid (div_valid),
        .flush     (flush),
        .req       (req),
        .div_ready (div_ready),
        .out_valid (out_valid),
        .result    (result)
    );

    div_unit_checker chk_i (
        .clk         (clk),
        .rst         (rst),
        .div_valid   (div_valid),
        .flush       (flush),
        .req         (req),
        .exp_chk     (exp_chk),
        .exp_val     (exp_val),
        .div_ready   (div_ready),
        .out_valid   (out_valid),
        .result      (result),
        .value_errs  (value_errs),
        .timing_errs (timing_errs)
    );

    bind div_unit div_unit_properties props_i (
        .clk       (clk),
        .rst       (rst),
        .div_ready (div_ready),
        .out_valid (out_valid)
    );

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [xlen-1:0] take_bits(int n);
        logic [xlen-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[xlen-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic void add_case(div_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b,
                                     logic [xlen-1:0] exp, logic [1:0] mode = 2'd0,
                                     logic [7:0] fa = 8'd0);
        stim_t s;
        s.op   = op;
        s.a    = a;
        s.b    = b;
        s.exp  = exp;
        s.chk  = (mode != 2'd2);
        s.mode = mode;
        s.fa   = fa;
        stim_q.push_back(s);
    endfunction

    // polls on falling edges.
    task automatic wait_for(input string what, input int limit, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < limit && !ok; n++) begin
            @(negedge clk);
            if (what == "reset") begin
                ok = !rst;
            end else if (what == "ready") begin
                ok = div_ready;
            end else begin
                ok = out_valid;
            end
        end
        if (!ok) begin
            timeout_errs++;
            $display("Timeout at %0t: %s did not arrive within %0d cycles", $time, what, limit);
        end
    endtask

    task automatic issue(input div_op_e op, input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                         input logic chk, input logic [xlen-1:0] exp, input logic fl);
        req.op       = op;
        req.dividend = a;
        req.divisor  = b;
        exp_chk      = chk;
        exp_val      = exp;
        div_valid    = 1'b1;
        flush        = fl;
        @(negedge clk);
        div_valid = 1'b0;
        flush     = 1'b0;
    endtask

    task automatic run_entry(input stim_t s, output bit ok);
        wait_for("ready", 200, ok);
        if (!ok) begin
            return;
        end
        if (s.mode == 2'd0) begin
            issue(s.op, s.a, s.b, s.chk, s.exp, 1'b0);
            wait_for("out_valid", 100, ok);
        end else if (s.mode == 2'd1) begin
            issue(op_divu, 64'd12345, 64'd7, 1'b0, '0, 1'b0);  // victim.
            repeat (s.fa) @(negedge clk);
            issue(s.op, s.a, s.b, s.chk, s.exp, 1'b1);
            wait_for("out_valid", 100, ok);
        end else begin
            issue(s.op, s.a, s.b, 1'b0, '0, 1'b0);
            repeat (s.fa) @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            wait_for("ready", 10, ok);
            repeat (70) @(negedge clk);  // room for a stray out_valid.
        end
    endtask

    initial begin
        stim_t           s;
        logic [xlen-1:0] r;
        bit              ok;
        int              total;
        div_valid    = 1'b0;
        flush        = 1'b0;
        req          = '0;
        exp_chk      = 1'b0;
        exp_val      = '0;
        timeout_errs = 0;
        lfsr         = 16'd28234;

        add_case(op_divu,  64'd100, 64'd7, 64'd14);
        add_case(op_remu,  64'd100, 64'd7, 64'd2);
        add_case(op_div,   -64'sd100, 64'd7, -64'sd14);
        add_case(op_rem,   -64'sd100, 64'd7, -64'sd2);
        add_case(op_rem,   64'd100, -64'sd7, 64'd2);
        add_case(op_div,   -64'sd100, -64'sd7, 64'd14);
        add_case(op_remu,  '1, 64'd10, 64'd5);
        add_case(op_divu,  '1, 64'd2, 64'h7FFF_FFFF_FFFF_FFFF);
        add_case(op_divu,  64'd42, 64'd0, '1);
        add_case(op_rem,   -64'sd5, 64'd0, -64'sd5);
        add_case(op_div,   64'h8000_0000_0000_0000, '1, 64'h8000_0000_0000_0000);
        add_case(op_rem,   64'h8000_0000_0000_0000, '1, 64'd0);
        add_case(op_divw,  64'h1234_5678_FFFF_FFF6, 64'hABCD_0000_0000_0003, -64'sd3);
        add_case(op_remw,  64'h1234_5678_FFFF_FFF6, 64'hABCD_0000_0000_0003, -64'sd1);
        add_case(op_divuw, 64'h1234_5678_FFFF_FFF6, 64'hABCD_0000_0000_0003, 64'h5555_5552);
        add_case(op_remuw, 64'hFFFF_FFFF, 64'h10, 64'hF);
        add_case(op_divuw, 64'hFFFF_FFFE, 64'd1, -64'sd2);
        add_case(op_divw,  64'h8000_0000, 64'hFFFF_FFFF, 64'hFFFF_FFFF_8000_0000);
        add_case(op_remw,  64'h8000_0000, 64'hFFFF_FFFF, 64'd0);
        add_case(op_remw,  64'h8000_0005, 64'h1_0000_0000, 64'hFFFF_FFFF_8000_0005);
        add_case(op_div,   64'd1000, -64'sd3, -64'sd333, 2'd1, 8'd20);
        add_case(op_divu,  64'd77, 64'd7, '0, 2'd2, 8'd30);
        add_case(op_rem,   64'd77, 64'd7, '0, 2'd2, 8'd64);  // flush in the done cycle.
        add_case(op_remu,  64'd1000, 64'd7, 64'd6, 2'd1, 8'd64);

        // random ops with the divisor shifted down to vary its size.
        for (int i = 0; i < 16; i++) begin
            r      = take_bits(3);
            s.op   = div_op_e'(r[2:0]);
            s.a    = take_bits(xlen);
            s.b    = take_bits(xlen);
            r      = take_bits(6);
            s.b    = s.b >> r[5:0];
            s.exp  = '0;
            s.chk  = 1'b0;
            s.mode = 2'd0;
            s.fa   = 8'd0;
            stim_q.push_back(s);
        end

        wait_for("reset", 50, ok);
        foreach (stim_q[i]) begin
            if (ok) begin
                run_entry(stim_q[i], ok);
            end
        end
        repeat (3) @(negedge clk);

        total = value_errs + timing_errs + timeout_errs + dut_i.props_i.assert_errs;
        $display("errors: value %0d, timing %0d, assertion %0d, timeout %0d",
                 value_errs, timing_errs, dut_i.props_i.assert_errs, timeout_errs);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* div_unit.f */
rtl/mdu_pkg.sv
rtl/div_operand_prep.sv
rtl/div_core.sv
rtl/div_result_fix.sv
rtl/div_unit.sv
tb/tb_clock_gen.sv
tb/div_unit_properties.sv
tb/div_unit_checker.sv
tb/div_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the div_unit testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module div_unit_tb -Mdir obj_dir -f div_unit.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep going after assertion errors so the closing report still prints.
output=$(./obj_dir/Vdiv_unit_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
